// ==== src/timer_pkg.sv ====
package timer_pkg;

	// register offsets inside the timer block
	typedef enum logic [1:0] {
		DIV_REG  = 2'd0,
		TIMA_REG = 2'd1,
		TMA_REG  = 2'd2,
		TAC_REG  = 2'd3
	} timer_reg_e;

	typedef logic [7:0]  timer_byte_t; // one register value
	typedef logic [13:0] div_count_t;  // machine-cycle divider
	typedef logic [1:0]  timer_sel_t;  // TAC clock select

	// divider bit used as TIMA clock, per TAC select
	localparam int unsigned TAP_SEL_00 = 7; // 256 cycles
	localparam int unsigned TAP_SEL_01 = 1; // 4 cycles
	localparam int unsigned TAP_SEL_10 = 3; // 16 cycles
	localparam int unsigned TAP_SEL_11 = 5; // 64 cycles

	// upper TAC bits have no storage and read high
	localparam logic [4:0] TAC_UNUSED_ONES = 5'b11111;

	// write strobes from the bus decoder, one per register
	typedef struct packed {
		logic        div_wr;
		logic        tima_wr;
		logic        tma_wr;
		logic        tac_wr;
		timer_byte_t wdata;
	} timer_wr_t;

	// register values as the bus sees them
	typedef struct packed {
		timer_byte_t div;
		timer_byte_t tima;
		timer_byte_t tma;
		timer_byte_t tac; // bits 7:3 always ones
	} timer_state_t;

endpackage

// ==== src/apb_pkg.sv ====
package apb_pkg;

	typedef logic [1:0] apb_addr_t; // register offset within the block
	typedef logic [7:0] apb_data_t; // byte-wide data path

	// requester side of the bus
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// high in the access phase of a transfer
	function automatic logic apb_access(input apb_req_t req);
		return req.psel && req.penable;
	endfunction

endpackage

// ==== src/div_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_counter
	import timer_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       reset,
	input  logic       div_wr,
	output div_count_t div_count
);

	div_count_t count;
	div_count_t count_next;

	// free-running count that any write to DIV restarts
	always_comb begin
		if (div_wr)
			count_next = '0;
		else
			count_next = count + 1'b1; // wraps after 16384 cycles
	end

	always_ff @(posedge boga1mhz) begin
		if (reset)
			count <= '0;
		else
			count <= count_next;
	end

	assign div_count = count; // DIV and the TIMA taps both come from here

endmodule

`default_nettype wire

// ==== src/tima_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module tima_counter
	import timer_pkg::*;
(
	input  logic         boga1mhz,
	input  logic         reset,
	input  timer_wr_t    wr,
	input  div_count_t   div_count,
	output timer_state_t state,
	output logic         int_timer
);

	timer_byte_t tima;
	timer_byte_t tma;
	logic        tac_en;     // TAC bit 2
	timer_sel_t  tac_sel;    // TAC bits 1:0

	logic        tap;        // selected divider bit
	logic        gated;      // tap AND enable
	logic        gated_q;    // gated, one cycle late
	logic        inc;        // falling edge seen on gated
	logic        overflow;
	timer_byte_t reload_val;
	timer_byte_t tima_next;

	// tap select as in the hardware mux tree
	always_comb begin
		case (tac_sel)
			2'b00:   tap = div_count[TAP_SEL_00];
			2'b01:   tap = div_count[TAP_SEL_01];
			2'b10:   tap = div_count[TAP_SEL_10];
			default: tap = div_count[TAP_SEL_11];
		endcase
	end

	// gating before the edge detect lets a disable or DIV clear
	// produce an extra count when the tap was high
	assign gated = tap && tac_en;
	assign inc   = gated_q && !gated;

	always_ff @(posedge boga1mhz) begin
		if (reset)
			gated_q <= 1'b0;
		else
			gated_q <= gated;
	end

	// a TMA write in the same cycle feeds the reload directly
	assign reload_val = wr.tma_wr ? wr.wdata : tma;
	assign overflow   = inc && (tima == 8'hff) && !wr.tima_wr;

	always_comb begin
		tima_next = tima;
		if (wr.tima_wr)
			tima_next = wr.wdata; // bus write beats the increment
		else if (overflow)
			tima_next = reload_val;
		else if (inc)
			tima_next = tima + 1'b1;
	end

	always_ff @(posedge boga1mhz) begin
		if (reset) begin
			tima <= '0;
		end else begin
			tima <= tima_next;
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (reset) begin
			tma     <= '0;
			tac_en  <= 1'b0;
			tac_sel <= '0;
		end else begin
			if (wr.tma_wr)
				tma <= wr.wdata;
			if (wr.tac_wr) begin
				tac_en  <= wr.wdata[2];
				tac_sel <= wr.wdata[1:0];
			end
		end
	end

	// single-cycle interrupt request
	always_ff @(posedge boga1mhz) begin
		if (reset)
			int_timer <= 1'b0;
		else
			int_timer <= overflow;
	end

	// register view for the read mux
	assign state.div  = div_count[13:6];
	assign state.tima = tima;
	assign state.tma  = tma;
	assign state.tac  = {TAC_UNUSED_ONES, tac_en, tac_sel};

	// the interrupt controller latches a pulse, never a level
	int_single_pulse: assert property (
		@(posedge boga1mhz) disable iff (reset)
		int_timer |=> !int_timer
	);

	// TIMA holds unless counted, reloaded or written
	tima_hold: assert property (
		@(posedge boga1mhz) disable iff (reset)
		!(inc || wr.tima_wr) |=> $stable(tima)
	);

endmodule

`default_nettype wire

// ==== src/timer_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer_apb_regs
	import timer_pkg::*;
	import apb_pkg::*;
(
	input  logic         boga1mhz,
	input  apb_req_t     apb_req,
	input  timer_state_t state,
	output timer_wr_t    wr,
	output apb_data_t    prdata
);

	logic       access;
	logic       wr_access;
	logic       rd_access;
	timer_reg_e reg_sel;

	// no wait states, so the access phase is always the last one
	assign access    = apb_access(apb_req);
	assign wr_access = access && apb_req.pwrite;
	assign rd_access = access && !apb_req.pwrite;
	assign reg_sel   = timer_reg_e'(apb_req.paddr);

	// one strobe per write, data goes to all registers
	always_comb begin
		wr       = '0;
		wr.wdata = apb_req.pwdata;
		if (wr_access) begin
			case (reg_sel)
				DIV_REG:  wr.div_wr  = 1'b1; // value ignored
				TIMA_REG: wr.tima_wr = 1'b1;
				TMA_REG:  wr.tma_wr  = 1'b1;
				TAC_REG:  wr.tac_wr  = 1'b1;
				default:  wr.div_wr  = 1'b0;
			endcase
		end
	end

	// read data only while a read is in its access phase
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			case (reg_sel)
				DIV_REG:  prdata = state.div;
				TIMA_REG: prdata = state.tima;
				TMA_REG:  prdata = state.tma;
				TAC_REG:  prdata = state.tac;
				default:  prdata = '0;
			endcase
		end
	end

	// a requester may not raise penable without a selected slave
	penable_needs_psel: assert property (
		@(posedge boga1mhz)
		apb_req.penable |-> apb_req.psel
	);

endmodule

`default_nettype wire

// ==== src/timer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer_top
	import timer_pkg::*;
	import apb_pkg::*;
(
	input  logic      boga1mhz,
	input  logic      reset,
	input  apb_req_t  apb_req,
	output apb_data_t prdata,
	output logic      int_timer
);

	timer_wr_t    wr;        // decoded write strobes
	div_count_t   div_count; // divider, also DIV source
	timer_state_t state;     // register readback

	timer_apb_regs apb_regs_i (
		.boga1mhz (boga1mhz),
		.apb_req  (apb_req),
		.state    (state),
		.wr       (wr),
		.prdata   (prdata)
	);

	div_counter div_i (
		.boga1mhz  (boga1mhz),
		.reset     (reset),
		.div_wr    (wr.div_wr),
		.div_count (div_count)
	);

	tima_counter tima_i (
		.boga1mhz  (boga1mhz),
		.reset     (reset),
		.wr        (wr),
		.div_count (div_count),
		.state     (state),
		.int_timer (int_timer)
	);

endmodule

`default_nettype wire

// ==== tb/timer_clock_gen.sv ====
`timescale 1ns/1ns

module timer_clock_gen (
	output logic boga1mhz,
	output logic reset
);

	localparam int HALF_PERIOD  = 20; // 40 ns machine cycle
	localparam int RESET_CYCLES = 2;

	initial begin
		boga1mhz = 1'b0;
		forever #HALF_PERIOD boga1mhz = ~boga1mhz;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge boga1mhz);
		#2 reset = 1'b0; // released like any other input, just after the edge
	end

endmodule

// ==== tb/timer_tb.sv ====
`timescale 1ns/1ns

module timer_tb
	import timer_pkg::*;
	import apb_pkg::*;
();

	localparam int DRIVE_DELAY = 2; // ns after the rising edge

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_IDLE,
		OP_IRQ
	} op_e;

	typedef struct packed {
		op_e         op;
		timer_reg_e  addr;
		timer_byte_t data;
		timer_byte_t expected;
		logic [15:0] len; // bus cycles the row takes
	} row_t;

	logic        boga1mhz;
	logic        reset;
	apb_req_t    apb_req;
	apb_data_t   prdata;
	logic        int_timer;

	row_t        rows[$];
	int          checks = 0;
	int          errors = 0;
	int          irq_count = 0;
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;

	timer_clock_gen clock_gen_i (
		.boga1mhz (boga1mhz),
		.reset    (reset)
	);

	timer_top dut_i (
		.boga1mhz  (boga1mhz),
		.reset     (reset),
		.apb_req   (apb_req),
		.prdata    (prdata),
		.int_timer (int_timer)
	);

	// pulse lasts a full cycle, so the falling edge sees it once
	always @(negedge boga1mhz) begin
		if (!reset && int_timer)
			irq_count++;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic write_reg(input timer_reg_e addr, input timer_byte_t data);
		@(posedge boga1mhz);
		#DRIVE_DELAY;
		apb_req.psel    = 1'b1; // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(posedge boga1mhz);
		#DRIVE_DELAY;
		apb_req.penable = 1'b1; // access, takes effect at the next edge
	endtask

	task automatic read_reg(input timer_reg_e addr, output timer_byte_t data);
		@(posedge boga1mhz);
		#DRIVE_DELAY;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		apb_req.pwdata  = '0;
		@(posedge boga1mhz);
		#DRIVE_DELAY;
		apb_req.penable = 1'b1;
		@(negedge boga1mhz);
		data = prdata; // mid access phase
	endtask

	task automatic idle_bus(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge boga1mhz);
			#DRIVE_DELAY;
			apb_req = '0;
			if (i == 0) begin
				@(negedge boga1mhz);
				check_value("prdata while idle", 32'h0, prdata);
			end
		end
	endtask

	// count runs from zero in the cycle after the clearing edge
	function automatic timer_byte_t div_expect(input int idle);
		return timer_byte_t'((idle + 1) / 64);
	endfunction

	// k-th tap fall after the DIV clear lands at clear edge + k*period + 1,
	// the read access phase sits idle + 3 cycles after that edge
	function automatic int tima_incs(input int idle, input int period);
		return (idle + 2) / period;
	endfunction

	function automatic int period_of(input timer_sel_t sel);
		case (sel)
			2'b00:   return 256;
			2'b01:   return 4;
			2'b10:   return 16;
			default: return 64;
		endcase
	endfunction

	task automatic add_row(input op_e op, input timer_reg_e addr, input timer_byte_t data,
			input timer_byte_t expected, input int len);
		row_t r;
		r.op       = op;
		r.addr     = addr;
		r.data     = data;
		r.expected = expected;
		r.len      = 16'(len);
		rows.push_back(r);
	endtask

	task automatic add_div_case(input int idle);
		add_row(OP_WRITE, DIV_REG, 8'hff, 8'h00, 2); // any value clears
		if (idle > 0)
			add_row(OP_IDLE, DIV_REG, 8'h00, 8'h00, idle);
		add_row(OP_READ, DIV_REG, 8'h00, div_expect(idle), 2);
	endtask

	task automatic add_rate_case(input timer_sel_t sel, input int periods);
		int period;
		int idle;
		period = period_of(sel);
		idle   = periods * period + period / 2 - 2; // read lands mid-period
		add_row(OP_WRITE, TAC_REG, {5'b00000, 1'b1, sel}, 8'h00, 2);
		add_row(OP_WRITE, DIV_REG, 8'h00, 8'h00, 2);
		add_row(OP_WRITE, TIMA_REG, 8'h00, 8'h00, 2);
		add_row(OP_IDLE, DIV_REG, 8'h00, 8'h00, idle);
		add_row(OP_READ, TIMA_REG, 8'h00, timer_byte_t'(tima_incs(idle, period)), 2);
	endtask

	task automatic build_table();
		// state after reset
		add_row(OP_READ, TIMA_REG, 8'h00, 8'h00, 2);
		add_row(OP_READ, TMA_REG, 8'h00, 8'h00, 2);
		add_row(OP_READ, TAC_REG, 8'h00, 8'hf8, 2);
		add_row(OP_IRQ, DIV_REG, 8'h00, 8'h00, 1);
		// readback, upper TAC bits read high
		add_row(OP_WRITE, TMA_REG, 8'h5a, 8'h00, 2);
		add_row(OP_READ, TMA_REG, 8'h00, 8'h5a, 2);
		add_row(OP_WRITE, TAC_REG, 8'h06, 8'h00, 2);
		add_row(OP_READ, TAC_REG, 8'h00, 8'hfe, 2);
		add_row(OP_WRITE, TAC_REG, 8'h03, 8'h00, 2);
		add_row(OP_READ, TAC_REG, 8'h00, 8'hfb, 2);
		// DIV, including the 64-cycle boundary
		add_div_case(0);
		add_div_case(62);
		add_div_case(63);
		add_div_case(200);
		add_div_case(1000);
		// TIMA rate for each select
		add_rate_case(2'b01, 10);
		add_rate_case(2'b10, 7);
		add_rate_case(2'b11, 5);
		add_rate_case(2'b00, 3);
		// timer off
		add_row(OP_WRITE, TAC_REG, 8'h01, 8'h00, 2);
		add_row(OP_WRITE, TIMA_REG, 8'h55, 8'h00, 2);
		add_row(OP_IDLE, DIV_REG, 8'h00, 8'h00, 300);
		add_row(OP_READ, TIMA_REG, 8'h00, 8'h55, 2);
		add_row(OP_READ, TAC_REG, 8'h00, 8'hf9, 2);
		// overflow, first increment reaches ff and the second reloads
		add_row(OP_WRITE, TMA_REG, 8'ha0, 8'h00, 2);
		add_row(OP_WRITE, TAC_REG, 8'h05, 8'h00, 2);
		add_row(OP_WRITE, DIV_REG, 8'h3c, 8'h00, 2);
		add_row(OP_WRITE, TIMA_REG, 8'hfe, 8'h00, 2);
		add_row(OP_IDLE, DIV_REG, 8'h00, 8'h00, 40);
		add_row(OP_READ, TIMA_REG, 8'h00, 8'ha0 + timer_byte_t'(tima_incs(40, 4) - 2), 2);
		add_row(OP_READ, TMA_REG, 8'h00, 8'ha0, 2);
		add_row(OP_IRQ, DIV_REG, 8'h00, 8'h01, 1);
	endtask

	initial begin : watchdog
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge boga1mhz);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", cycle_limit);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	end

	initial begin : main
		int unsigned total;
		timer_reg_e  reg_name;
		timer_byte_t rdata;
		apb_req = '0;
		total   = 0;
		build_table();
		foreach (rows[i])
			total += rows[i].len;
		cycle_limit = total + 100; // reset and slack
		@(negedge reset);
		foreach (rows[i]) begin
			reg_name = rows[i].addr;
			case (rows[i].op)
				OP_WRITE: write_reg(reg_name, rows[i].data);
				OP_READ: begin
					read_reg(reg_name, rdata);
					check_value($sformatf("prdata %s", reg_name.name()), rows[i].expected, rdata);
				end
				OP_IDLE: idle_bus(rows[i].len);
				default: begin
					idle_bus(1);
					check_value("int_timer pulses", rows[i].expected, irq_count);
				end
			endcase
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== project.f ====
src/timer_pkg.sv
src/apb_pkg.sv
src/div_counter.sv
src/tima_counter.sv
src/timer_apb_regs.sv
src/timer_top.sv
tb/timer_clock_gen.sv
tb/timer_tb.sv

// ==== Bender.yml ====
package:
  name: timer

sources:
  - files:
      - src/timer_pkg.sv
      - src/apb_pkg.sv
      - src/div_counter.sv
      - src/tima_counter.sv
      - src/timer_apb_regs.sv
      - src/timer_top.sv
  - target: test
    files:
      - tb/timer_clock_gen.sv
      - tb/timer_tb.sv
